//--- run.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pwo_tb -f tb.f -o pwo_sim

# A $fatal in the run gives a nonzero exit status
./obj_dir/pwo_sim

//--- src/coef_ram.sv
`include "pwo_config.svh"

module coef_ram (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   zeroize,
    input  logic                   wr_en,
    input  logic [`PWO_ADDR_W-1:0] wr_addr,
    input  logic [`PWO_WORD_W-1:0] wr_data,
    input  logic                   rd_en,
    input  logic [`PWO_ADDR_W-1:0] rd_addr,
    output logic [`PWO_WORD_W-1:0] rd_data
);

    // ==============================
    // Storage
    // ==============================

    // One word holds four packed coefficients
    logic [`PWO_WORD_W-1:0] mem [0:(1 << `PWO_ADDR_W)-1];

    // Write port, zeroize wipes every word at once
    always_ff @(posedge clk) begin
        if (zeroize) begin
            for (int i = 0; i < (1 << `PWO_ADDR_W); i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ==============================
    // Read port
    // ==============================

    // Registered read, data one cycle after rd_en
    // Holds its value between reads
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else if (zeroize) begin
            // Scrub the output register too
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- src/mod_arith_lane.sv
`include "pwo_config.svh"

module mod_arith_lane (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   zeroize,
    input  logic                   in_valid,
    input  pwo_pkg::mode_t         mode,
    input  logic                   accumulate,
    input  logic [`PWO_COEF_W-1:0] a,
    input  logic [`PWO_COEF_W-1:0] b,
    input  logic [`PWO_COEF_W-1:0] c_old,
    output logic [`PWO_COEF_W-1:0] result
);

    // Stage valids
    logic s1_valid, s2_valid;
    // Raw op result, wide enough for the full product
    logic [2*`PWO_COEF_W-1:0] s1_raw;
    // Reduced result
    logic [`PWO_COEF_W-1:0] s2_red;
    // Old C delay line, follows the item down the pipe
    logic [`PWO_COEF_W-1:0] c_d1, c_d2;
    // Accumulate path
    logic [`PWO_COEF_W-1:0] c_term;
    logic [`PWO_COEF_W:0] acc_sum;
    logic [`PWO_COEF_W-1:0] acc_red;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (zeroize) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
        end
    end

    // ==============================
    // Stage 1: raw op
    // ==============================
    always_ff @(posedge clk) begin
        if (zeroize) begin
            s1_raw <= '0;
            c_d1   <= '0;
        end else if (in_valid) begin
            case (mode)
                pwo_pkg::PWM: s1_raw <= a * b;
                pwo_pkg::PWA: s1_raw <= a + b;
                // Offset by q so the difference stays non-negative
                pwo_pkg::PWS: s1_raw <= a + `PWO_Q - b;
                default:      s1_raw <= '0;
            endcase
            c_d1 <= c_old;
        end
    end

    // ==============================
    // Stage 2: reduce mod q
    // ==============================
    always_ff @(posedge clk) begin
        if (zeroize) begin
            s2_red <= '0;
            c_d2   <= '0;
        end else if (s1_valid) begin
            s2_red <= `PWO_COEF_W'(s1_raw % `PWO_Q);
            c_d2   <= c_d1;
        end
    end

    // Stage 3: optional accumulate, one conditional subtract
    assign c_term  = accumulate ? c_d2 : '0;
    assign acc_sum = {1'b0, s2_red} + {1'b0, c_term};
    assign acc_red = `PWO_COEF_W'((acc_sum >= `PWO_Q) ? acc_sum - `PWO_Q : acc_sum);

    always_ff @(posedge clk) begin
        if (zeroize) begin
            result <= '0;
        end else if (s2_valid) begin
            result <= acc_red;
        end
    end

endmodule

//--- src/pwo_config.svh
`ifndef PWO_CONFIG_SVH
`define PWO_CONFIG_SVH

// ==============================
// Arithmetic
// ==============================

// Dilithium prime, 2^23 - 2^13 + 1
`define PWO_Q 24'd8380417

// One coefficient per lane
`define PWO_COEF_W 24

// ==============================
// Memory layout
// ==============================

// Four coefficients per memory word
`define PWO_LANES 4
`define PWO_WORD_W 96

// 64 words per memory, enough for four polynomials
`define PWO_ADDR_W 6
`define PWO_POLY_WORDS 16

`endif

//--- src/pwo_ctrl.sv
`include "pwo_config.svh"

module pwo_ctrl (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   zeroize,
    input  logic                   start,
    input  logic                   sampler_mode,
    input  logic                   sampler_valid,
    input  logic [`PWO_ADDR_W-1:0] base_a,
    input  logic [`PWO_ADDR_W-1:0] base_b,
    input  logic [`PWO_ADDR_W-1:0] base_c,
    output logic                   rd_en,
    output logic [`PWO_ADDR_W-1:0] rd_addr_a,
    output logic [`PWO_ADDR_W-1:0] rd_addr_b,
    output logic [`PWO_ADDR_W-1:0] rd_addr_c,
    output logic                   lane_valid,
    output logic                   wr_en,
    output logic [`PWO_ADDR_W-1:0] wr_addr,
    output logic                   busy,
    output logic                   done
);

    pwo_pkg::ctrl_state_t state;
    // Sampler mode as latched at start
    logic samp_q;
    logic [`PWO_ADDR_W-1:0] base_a_q, base_b_q, base_c_q;
    // Word index of the next read
    logic [`PWO_ADDR_W-1:0] issue_cnt;
    logic last_issue;
    // In-flight tracking, bit 0 is read data, bit 3 is the C write
    logic [3:0] v_pipe;
    logic [`PWO_ADDR_W-1:0] addr_pipe [4];

    // ==============================
    // Read issue
    // ==============================

    // Memory mode reads every RUN cycle, sampler mode only on a strobe
    assign rd_en      = (state == pwo_pkg::RUN) && (!samp_q || sampler_valid);
    assign last_issue = (issue_cnt == `PWO_ADDR_W'(`PWO_POLY_WORDS - 1));

    // Addresses wrap at the memory depth
    assign rd_addr_a = base_a_q + issue_cnt;
    assign rd_addr_b = base_b_q + issue_cnt;
    assign rd_addr_c = base_c_q + issue_cnt;

    assign lane_valid = v_pipe[0];
    assign wr_en      = v_pipe[3];
    assign wr_addr    = addr_pipe[3];
    assign busy       = (state != pwo_pkg::IDLE);

    // ==============================
    // FSM
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= pwo_pkg::IDLE;
            issue_cnt <= '0;
            samp_q    <= 1'b0;
            done      <= 1'b0;
        end else if (zeroize) begin
            // Abort without done
            state     <= pwo_pkg::IDLE;
            issue_cnt <= '0;
            samp_q    <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                pwo_pkg::IDLE: begin
                    if (start) begin
                        state     <= pwo_pkg::RUN;
                        issue_cnt <= '0;
                        samp_q    <= sampler_mode;
                    end
                end
                pwo_pkg::RUN: begin
                    if (rd_en) begin
                        issue_cnt <= issue_cnt + 1'b1;
                        if (last_issue) begin
                            state <= pwo_pkg::DRAIN;
                        end
                    end
                end
                pwo_pkg::DRAIN: begin
                    // Last write is in this cycle once the upper stages are empty
                    if (v_pipe[2:0] == 3'b000) begin
                        state <= pwo_pkg::IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= pwo_pkg::IDLE;
            endcase
        end
    end

    // Bases held for the whole operation
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            base_a_q <= base_a;
            base_b_q <= base_b;
            base_c_q <= base_c;
        end
    end

    // Valid line matches 1 memory cycle plus 3 lane stages
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v_pipe <= '0;
        end else if (zeroize) begin
            v_pipe <= '0;
        end else begin
            v_pipe <= {v_pipe[2:0], rd_en};
        end
    end

    // C address rides alongside, becomes the write address
    always_ff @(posedge clk) begin
        addr_pipe[0] <= rd_addr_c;
        for (int k = 1; k < 4; k++) begin
            addr_pipe[k] <= addr_pipe[k-1];
        end
    end

endmodule

//--- src/pwo_pkg.sv
package pwo_pkg;

    // ==============================
    // Opcodes and selectors
    // ==============================

    // Pointwise opcodes, no NTT passes here
    typedef enum logic [1:0] {
        PWM = 2'd0,
        PWA = 2'd1,
        PWS = 2'd2
    } mode_t;

    // Target memory of a load strobe
    typedef enum logic [1:0] {
        MEM_A = 2'd0,
        MEM_B = 2'd1,
        MEM_C = 2'd2
    } mem_sel_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } ctrl_state_t;

endpackage

//--- src/pwo_wrapper.sv
`include "pwo_config.svh"

module pwo_wrapper (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   zeroize,
    input  pwo_pkg::mode_t         mode,
    input  logic                   start,
    input  logic                   accumulate,
    input  logic                   sampler_mode,
    input  logic                   sampler_valid,
    input  logic [`PWO_WORD_W-1:0] sampler_data,
    input  logic [`PWO_ADDR_W-1:0] base_a,
    input  logic [`PWO_ADDR_W-1:0] base_b,
    input  logic [`PWO_ADDR_W-1:0] base_c,
    input  logic                   load_valid,
    input  pwo_pkg::mem_sel_t      load_sel,
    input  logic [`PWO_ADDR_W-1:0] load_addr,
    input  logic [`PWO_WORD_W-1:0] load_data,
    input  logic                   host_rd_en,
    input  logic [`PWO_ADDR_W-1:0] host_rd_addr,
    output logic [`PWO_WORD_W-1:0] host_rd_data,
    output logic                   busy,
    output logic                   done
);

    // Operation settings latched at start
    pwo_pkg::mode_t mode_q;
    logic acc_q, samp_q;
    // Controller side
    logic eng_rd_en, lane_valid, eng_wr_en;
    logic [`PWO_ADDR_W-1:0] rd_addr_a, rd_addr_b, rd_addr_c, eng_wr_addr;
    // Memory side
    logic load_a, load_b, load_c, host_rd_ok;
    logic c_wr_en, c_rd_en;
    logic [`PWO_ADDR_W-1:0] c_wr_addr, c_rd_addr;
    logic [`PWO_WORD_W-1:0] c_wr_data;
    logic [`PWO_WORD_W-1:0] a_rd_data, b_rd_data, c_rd_data;
    // B source and lane results
    logic [`PWO_WORD_W-1:0] samp_word_q, b_word, lane_word;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode_q <= pwo_pkg::PWM;
            acc_q  <= 1'b0;
            samp_q <= 1'b0;
        end else if (start && !busy) begin
            mode_q <= mode;
            acc_q  <= accumulate;
            samp_q <= sampler_mode;
        end
    end

    // ==============================
    // Host ports
    // ==============================

    // Loads and host reads only while idle
    assign load_a     = load_valid && !busy && (load_sel == pwo_pkg::MEM_A);
    assign load_b     = load_valid && !busy && (load_sel == pwo_pkg::MEM_B);
    assign load_c     = load_valid && !busy && (load_sel == pwo_pkg::MEM_C);
    assign host_rd_ok = host_rd_en && !busy;

    // C ports shared, engine wins while busy
    assign c_wr_en   = eng_wr_en || load_c;
    assign c_wr_addr = eng_wr_en ? eng_wr_addr : load_addr;
    assign c_wr_data = eng_wr_en ? lane_word : load_data;
    assign c_rd_en   = eng_rd_en || host_rd_ok;
    assign c_rd_addr = busy ? rd_addr_c : host_rd_addr;

    assign host_rd_data = c_rd_data;

    pwo_ctrl u_ctrl (
        .clk(clk), .arst_n(arst_n), .zeroize(zeroize),
        .start(start),
        .sampler_mode(sampler_mode), .sampler_valid(sampler_valid),
        .base_a(base_a), .base_b(base_b), .base_c(base_c),
        .rd_en(eng_rd_en),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b), .rd_addr_c(rd_addr_c),
        .lane_valid(lane_valid),
        .wr_en(eng_wr_en), .wr_addr(eng_wr_addr),
        .busy(busy), .done(done)
    );

    coef_ram mem_a (
        .clk(clk), .arst_n(arst_n), .zeroize(zeroize),
        .wr_en(load_a), .wr_addr(load_addr), .wr_data(load_data),
        .rd_en(eng_rd_en), .rd_addr(rd_addr_a), .rd_data(a_rd_data)
    );

    // No B read in sampler mode
    coef_ram mem_b (
        .clk(clk), .arst_n(arst_n), .zeroize(zeroize),
        .wr_en(load_b), .wr_addr(load_addr), .wr_data(load_data),
        .rd_en(eng_rd_en && !samp_q), .rd_addr(rd_addr_b), .rd_data(b_rd_data)
    );

    coef_ram mem_c (
        .clk(clk), .arst_n(arst_n), .zeroize(zeroize),
        .wr_en(c_wr_en), .wr_addr(c_wr_addr), .wr_data(c_wr_data),
        .rd_en(c_rd_en), .rd_addr(c_rd_addr), .rd_data(c_rd_data)
    );

    // ==============================
    // Sampler mux and lanes
    // ==============================

    // Captured on the strobe, lines up with the A data one cycle later
    always_ff @(posedge clk) begin
        if (zeroize) begin
            samp_word_q <= '0;
        end else if (sampler_valid) begin
            samp_word_q <= sampler_data;
        end
    end

    assign b_word = samp_q ? samp_word_q : b_rd_data;

    for (genvar l = 0; l < `PWO_LANES; l++) begin : g_lane
        mod_arith_lane u_lane (
            .clk(clk), .arst_n(arst_n), .zeroize(zeroize),
            .in_valid(lane_valid), .mode(mode_q), .accumulate(acc_q),
            .a(a_rd_data[l*`PWO_COEF_W +: `PWO_COEF_W]),
            .b(b_word[l*`PWO_COEF_W +: `PWO_COEF_W]),
            .c_old(c_rd_data[l*`PWO_COEF_W +: `PWO_COEF_W]),
            .result(lane_word[l*`PWO_COEF_W +: `PWO_COEF_W])
        );
    end

endmodule

//--- tb.f
+incdir+src
src/pwo_pkg.sv
src/coef_ram.sv
src/mod_arith_lane.sv
src/pwo_ctrl.sv
src/pwo_wrapper.sv
verification/pwo_chk.sv
verification/pwo_tb.sv

//--- verification/pwo_chk.sv
module pwo_chk (
    input logic clk,
    input logic arst_n,
    input logic busy,
    input logic done
);

    // ==============================
    // Control output rules
    // ==============================

    // done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Controller is back in IDLE when done fires
    busy_low_at_done: assert property (@(posedge clk) disable iff (!arst_n) done |-> !busy)
        else $error("busy still high in the cycle of done");

    // First edge after reset release
    quiet_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> (!busy && !done))
        else $error("busy or done high right after reset");

endmodule

//--- verification/pwo_tb.sv
`include "pwo_config.svh"

module pwo_tb;

    localparam int NUM_CASES = 8;
    localparam int DEPTH = 1 << `PWO_ADDR_W;
    // One 400-cycle slot per case, one more for the initial load and zeroize
    localparam int WATCHDOG_CYCLES = (NUM_CASES + 1) * 400;

    // One table row, exp_lat of zero skips the latency check
    typedef struct packed {
        pwo_pkg::mode_t mode;
        logic acc;
        logic samp;
        logic [`PWO_ADDR_W-1:0] base_a;
        logic [`PWO_ADDR_W-1:0] base_b;
        logic [`PWO_ADDR_W-1:0] base_c;
        logic [4:0] exp_lat;
    } case_t;

    logic clk, arst_n, zeroize;
    pwo_pkg::mode_t mode;
    logic start, accumulate, sampler_mode, sampler_valid;
    logic [`PWO_WORD_W-1:0] sampler_data;
    logic [`PWO_ADDR_W-1:0] base_a, base_b, base_c;
    logic load_valid;
    pwo_pkg::mem_sel_t load_sel;
    logic [`PWO_ADDR_W-1:0] load_addr, host_rd_addr;
    logic [`PWO_WORD_W-1:0] load_data, host_rd_data;
    logic host_rd_en, busy, done;

    // Mirror memories of the model
    logic [`PWO_WORD_W-1:0] model_a [DEPTH];
    logic [`PWO_WORD_W-1:0] model_b [DEPTH];
    logic [`PWO_WORD_W-1:0] model_c [DEPTH];
    logic [`PWO_WORD_W-1:0] samp_words [`PWO_POLY_WORDS];
    case_t cases [NUM_CASES];
    int seed;

    pwo_wrapper pwo_wrapper_i (.*);

    bind pwo_wrapper pwo_chk chk_i (.clk(clk), .arst_n(arst_n), .busy(busy), .done(done));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    // ==============================
    // Helpers
    // ==============================

    // Inputs change 1 unit after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [`PWO_COEF_W-1:0] rand_coef();
        return `PWO_COEF_W'($unsigned($random(seed)) % `PWO_Q);
    endfunction

    function automatic logic [`PWO_WORD_W-1:0] rand_word();
        logic [`PWO_WORD_W-1:0] w;
        for (int l = 0; l < `PWO_LANES; l++) begin
            w[l*`PWO_COEF_W +: `PWO_COEF_W] = rand_coef();
        end
        return w;
    endfunction

    // Pointwise rule per coefficient, all math mod q
    function automatic logic [`PWO_COEF_W-1:0] expect_coef(pwo_pkg::mode_t op, logic acc,
            longint a, longint b, longint c_old);
        longint q;
        longint r;
        q = `PWO_Q;
        case (op)
            pwo_pkg::PWM: r = (a * b) % q;
            pwo_pkg::PWA: r = (a + b) % q;
            pwo_pkg::PWS: r = (a + q - b) % q;
            default:      r = 0;
        endcase
        if (acc) r = (r + c_old) % q;
        return `PWO_COEF_W'(r);
    endfunction

    task automatic load_word(pwo_pkg::mem_sel_t sel, logic [`PWO_ADDR_W-1:0] addr,
            logic [`PWO_WORD_W-1:0] data);
        load_valid = 1'b1;
        load_sel   = sel;
        load_addr  = addr;
        load_data  = data;
        tick();
        load_valid = 1'b0;
    endtask

    // Host read, data is valid right after the next edge
    task automatic read_c(logic [`PWO_ADDR_W-1:0] addr, output logic [`PWO_WORD_W-1:0] data);
        host_rd_en   = 1'b1;
        host_rd_addr = addr;
        tick();
        data = host_rd_data;
        host_rd_en = 1'b0;
    endtask

    // Whole C memory, so words outside the target region are covered too
    task automatic check_c_all(string tag);
        logic [`PWO_WORD_W-1:0] got;
        for (int a = 0; a < DEPTH; a++) begin
            read_c(`PWO_ADDR_W'(a), got);
            assert (got === model_c[a])
            else report_failure($sformatf("mismatch at time %0t: %s C[%0d] got %h expected %h",
                $time, tag, a, got, model_c[a]));
        end
    endtask

    // Sampler strobes with random gaps of 0 to 3 cycles
    task automatic feed_sampler();
        int gap;
        for (int i = 0; i < `PWO_POLY_WORDS; i++) begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) tick();
            sampler_valid = 1'b1;
            sampler_data  = samp_words[i];
            tick();
            sampler_valid = 1'b0;
        end
    endtask

    // Counts cycles from the start edge, busy must hold from the next cycle until done
    task automatic wait_done(int exp_lat);
        int n;
        n = 0;
        while (!done) begin
            assert (busy)
            else report_failure($sformatf("mismatch at time %0t: busy low at cycle %0d",
                $time, n));
            tick();
            n++;
            if (n > 300) report_failure("done did not arrive within 300 cycles");
        end
        assert (!busy)
        else report_failure($sformatf("mismatch at time %0t: busy high with done", $time));
        // Latency runs to the edge where done falls
        tick();
        n++;
        if (exp_lat != 0) begin
            assert (!done && n == exp_lat)
            else report_failure($sformatf("mismatch at time %0t: done fell after %0d cycles, not %0d",
                $time, n, exp_lat));
        end
    endtask

    // ==============================
    // One table row
    // ==============================
    task automatic run_case(case_t c, int idx);
        logic [`PWO_ADDR_W-1:0] addr;
        logic [`PWO_WORD_W-1:0] w;
        logic [`PWO_WORD_W-1:0] a_w;
        logic [`PWO_WORD_W-1:0] b_w;
        logic [`PWO_WORD_W-1:0] c_w;
        for (int i = 0; i < `PWO_POLY_WORDS; i++) begin
            addr = c.base_a + `PWO_ADDR_W'(i);
            w = rand_word();
            model_a[addr] = w;
            load_word(pwo_pkg::MEM_A, addr, w);
            if (c.samp) begin
                samp_words[i] = rand_word();
            end else begin
                addr = c.base_b + `PWO_ADDR_W'(i);
                w = rand_word();
                model_b[addr] = w;
                load_word(pwo_pkg::MEM_B, addr, w);
            end
        end
        // Expected C, target words never overlap within one operation
        for (int i = 0; i < `PWO_POLY_WORDS; i++) begin
            a_w = model_a[c.base_a + `PWO_ADDR_W'(i)];
            b_w = c.samp ? samp_words[i] : model_b[c.base_b + `PWO_ADDR_W'(i)];
            addr = c.base_c + `PWO_ADDR_W'(i);
            c_w = model_c[addr];
            for (int l = 0; l < `PWO_LANES; l++) begin
                w[l*`PWO_COEF_W +: `PWO_COEF_W] = expect_coef(c.mode, c.acc,
                    a_w[l*`PWO_COEF_W +: `PWO_COEF_W], b_w[l*`PWO_COEF_W +: `PWO_COEF_W],
                    c_w[l*`PWO_COEF_W +: `PWO_COEF_W]);
            end
            model_c[addr] = w;
        end
        mode         = c.mode;
        accumulate   = c.acc;
        sampler_mode = c.samp;
        base_a       = c.base_a;
        base_b       = c.base_b;
        base_c       = c.base_c;
        start        = 1'b1;
        tick();
        start = 1'b0;
        if (c.samp) begin
            fork
                feed_sampler();
                wait_done(0);
            join
        end else begin
            wait_done(int'(c.exp_lat));
        end
        check_c_all($sformatf("case %0d", idx));
    endtask

    // Abort a running operation, then every C word reads back zero
    task automatic zeroize_check();
        mode         = pwo_pkg::PWM;
        accumulate   = 1'b0;
        sampler_mode = 1'b0;
        start        = 1'b1;
        tick();
        start = 1'b0;
        repeat (6) tick();
        zeroize = 1'b1;
        tick();
        zeroize = 1'b0;
        assert (!busy) else report_failure("busy still high after zeroize");
        repeat (8) begin
            tick();
            assert (!done) else report_failure("done pulsed after zeroize aborted the operation");
        end
        for (int a = 0; a < DEPTH; a++) begin
            model_a[a] = '0;
            model_b[a] = '0;
            model_c[a] = '0;
        end
        check_c_all("zeroize");
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        logic [`PWO_WORD_W-1:0] w;
        arst_n        = 1'b0;
        zeroize       = 1'b0;
        mode          = pwo_pkg::PWM;
        start         = 1'b0;
        accumulate    = 1'b0;
        sampler_mode  = 1'b0;
        sampler_valid = 1'b0;
        sampler_data  = '0;
        base_a        = '0;
        base_b        = '0;
        base_c        = '0;
        load_valid    = 1'b0;
        load_sel      = pwo_pkg::MEM_A;
        load_addr     = '0;
        load_data     = '0;
        host_rd_en    = 1'b0;
        host_rd_addr  = '0;
        seed          = 32'hd4c2_6d82;

        // mode, acc, sampler, base A, base B, base C, latency
        cases[0] = '{pwo_pkg::PWM, 1'b0, 1'b0, 6'd0,  6'd0,  6'd0,  5'd21};
        cases[1] = '{pwo_pkg::PWA, 1'b0, 1'b0, 6'd16, 6'd16, 6'd16, 5'd21};
        cases[2] = '{pwo_pkg::PWS, 1'b0, 1'b0, 6'd32, 6'd32, 6'd32, 5'd21};
        cases[3] = '{pwo_pkg::PWM, 1'b1, 1'b0, 6'd32, 6'd48, 6'd32, 5'd21};
        cases[4] = '{pwo_pkg::PWA, 1'b0, 1'b1, 6'd5,  6'd0,  6'd20, 5'd0};
        cases[5] = '{pwo_pkg::PWM, 1'b1, 1'b1, 6'd56, 6'd60, 6'd50, 5'd0};
        cases[6] = '{pwo_pkg::PWS, 1'b0, 1'b0, 6'd60, 6'd40, 6'd58, 5'd21};
        cases[7] = '{pwo_pkg::PWA, 1'b1, 1'b0, 6'd50, 6'd3,  6'd7,  5'd21};

        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Random C background, later accumulates build on it
        for (int a = 0; a < DEPTH; a++) begin
            w = rand_word();
            model_c[a] = w;
            load_word(pwo_pkg::MEM_C, `PWO_ADDR_W'(a), w);
        end
        check_c_all("initial load");

        for (int k = 0; k < NUM_CASES; k++) begin
            run_case(cases[k], k);
        end
        zeroize_check();

        $display("Test passed");
        $finish;
    end

endmodule
